// File: Makefile
TOP     = tb_dbg_bridge
OBJ_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary -j 0 --top-module $(TOP) -Mdir $(OBJ_DIR) -f dbg_bridge_top.f
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)

// File: dbg_bridge_top.f
+incdir+hw
hw/dbg_bridge_pkg.sv
hw/dbg_axi_master.sv
hw/axi_sram_slave.sv
hw/dbg_bridge_top.sv
verif/tb_dbg_bridge.sv

// File: hw/axi_sram_slave.sv
`default_nettype none

`include "dbg_bridge_consts.svh"

module axi_sram_slave import dbg_bridge_pkg::*; (
    input  wire logic     clk,
    input  wire logic     nrst,
    input  wire axi_m2s_t i_axi,
    output axi_s2m_t      o_axi
);

    localparam int WADDR_BITS = $clog2(`SRAM_WORDS);

    typedef logic [WADDR_BITS-1:0] word_addr_t;

    typedef enum logic [1:0] {
        s_idle,
        s_read_burst,
        s_write_data,
        s_write_resp
    } state_t;

    state_t     state, state_nxt;
    dbg_data_t  mem [`SRAM_WORDS];
    word_addr_t waddr;       // Word being read or written.
    logic [1:0] burst;       // Burst type of the current transfer.
    axi_len_t   beat_cnt;
    axi_len_t   beat_len;
    logic       rd_go;
    logic       wr_go;
    logic       w_go;

    // Handshakes and beats are all decoded from the state.
    always_comb begin
        o_axi.ar_ready = (state == s_idle);
        o_axi.aw_ready = (state == s_idle) && !i_axi.ar_valid;  // A read wins a tie.
        o_axi.w_ready  = (state == s_write_data);
        o_axi.b_valid  = (state == s_write_resp);
        o_axi.r_valid  = (state == s_read_burst);
        o_axi.r_data   = mem[waddr];
        o_axi.r_last   = (state == s_read_burst) && (beat_cnt == beat_len);
    end

    assign rd_go = o_axi.ar_ready && i_axi.ar_valid;
    assign wr_go = o_axi.aw_ready && i_axi.aw_valid;
    assign w_go  = o_axi.w_ready && i_axi.w_valid;

    always_comb begin
        state_nxt = state;
        case (state)
            s_idle: begin
                if (rd_go) begin
                    state_nxt = s_read_burst;
                end else if (wr_go) begin
                    state_nxt = s_write_data;
                end
            end
            s_read_burst: begin
                if (o_axi.r_last) begin
                    state_nxt = s_idle;
                end
            end
            s_write_data: begin
                if (w_go && i_axi.w_last) begin
                    state_nxt = s_write_resp;
                end
            end
            s_write_resp: state_nxt = s_idle;  // b_valid lasts one cycle.
            default:      state_nxt = s_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state    <= s_idle;
            beat_cnt <= '0;
            beat_len <= '0;
        end else begin
            state <= state_nxt;
            if (rd_go) begin
                beat_cnt <= '0;
                beat_len <= i_axi.ar.len;
            end else if (o_axi.r_valid) begin
                beat_cnt <= beat_cnt + 8'd1;
            end
        end
    end

    // Address bits below 3 select a byte within the word and are dropped.
    always_ff @(posedge clk) begin
        if (rd_go) begin
            waddr <= i_axi.ar.addr[WADDR_BITS+2:3];
            burst <= i_axi.ar.burst;
        end else if (wr_go) begin
            waddr <= i_axi.aw.addr[WADDR_BITS+2:3];
            burst <= i_axi.aw.burst;
        end else if ((o_axi.r_valid || w_go) && burst == `AXI_BURST_INCR) begin
            waddr <= waddr + word_addr_t'(1);  // Next word of an incrementing burst.
        end
    end

    // Byte-wise write under the strobes.
    always_ff @(posedge clk) begin
        if (w_go) begin
            for (int i = 0; i < `DBG_DATA_BITS/8; i++) begin
                if (i_axi.w_strb[i]) begin
                    mem[waddr][8*i +: 8] <= i_axi.w_data[8*i +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/dbg_axi_master.sv
`default_nettype none

`include "dbg_bridge_consts.svh"

module dbg_axi_master import dbg_bridge_pkg::*; (
    input  wire logic     clk,
    input  wire logic     nrst,
    input  wire logic     i_req_valid,
    input  wire dbg_req_t i_req,
    output logic          o_req_ready,
    output logic          o_resp_valid,
    output dbg_data_t     o_resp_rdata,
    output axi_m2s_t      o_axi,
    input  wire axi_s2m_t i_axi
);

    typedef enum logic [2:0] {
        s_idle,
        s_addr_read,
        s_read_data,
        s_addr_write,
        s_write_data,
        s_write_resp
    } state_t;

    state_t    state, state_nxt;
    axi_len_t  burst_cnt, burst_cnt_nxt;
    axi_len_t  burst_len, burst_len_nxt;
    logic [1:0] offs, offs_nxt;   // Halfword offset of the request.
    logic [2*`DBG_DATA_BITS-1:0] burst_buf, burst_buf_nxt;
    dbg_data_t w_data, w_data_nxt;
    dbg_strb_t w_strb, w_strb_nxt;
    axi_ax_t   rd_ax;
    axi_ax_t   wr_ax;

    // Picks the result out of the beat buffer. The newest beat sits in the low word.
    function automatic dbg_data_t select_rdata(input logic [1:0] offset,
                                               input logic [2*`DBG_DATA_BITS-1:0] beats);
        case (offset)
            2'b01:   select_rdata = {16'd0, beats[63:16]};
            2'b10:   select_rdata = {32'd0, beats[63:32]};
            2'b11:   select_rdata = {beats[47:0], beats[127:112]};  // Spans two words.
            default: select_rdata = beats[63:0];
        endcase
    endfunction

    // Address payloads come straight from the held request.
    always_comb begin
        rd_ax.addr = i_req.addr;
        rd_ax.size = `AXI_SIZE_8B;
        if (i_req.addr[2:1] == 2'b11) begin
            rd_ax.len   = 8'd1;
            rd_ax.burst = `AXI_BURST_INCR;
        end else begin
            rd_ax.len   = 8'd0;
            rd_ax.burst = `AXI_BURST_FIXED;
        end

        wr_ax       = rd_ax;
        wr_ax.len   = 8'd0;  // Writes never leave their word.
        wr_ax.burst = `AXI_BURST_FIXED;
    end

    always_comb begin
        state_nxt     = state;
        burst_cnt_nxt = burst_cnt;
        burst_len_nxt = burst_len;
        offs_nxt      = offs;
        burst_buf_nxt = burst_buf;
        w_data_nxt    = w_data;
        w_strb_nxt    = w_strb;

        o_req_ready  = 1'b0;
        o_resp_valid = 1'b0;
        o_resp_rdata = '0;

        o_axi.aw_valid = 1'b0;
        o_axi.aw       = wr_ax;
        o_axi.w_valid  = 1'b0;
        o_axi.w_data   = w_data;
        o_axi.w_strb   = w_strb;
        o_axi.w_last   = 1'b1;   // Every write is a single beat.
        o_axi.ar_valid = 1'b0;
        o_axi.ar       = rd_ax;

        case (state)
            s_idle: begin
                if (i_req_valid) begin
                    if (i_req.wr) begin
                        o_axi.aw_valid = 1'b1;
                        state_nxt      = s_addr_write;
                    end else begin
                        o_axi.ar_valid = 1'b1;
                        state_nxt      = s_addr_read;
                    end
                end
            end
            s_addr_read:  o_axi.ar_valid = 1'b1;
            s_addr_write: o_axi.aw_valid = 1'b1;
            s_read_data: begin
                if (i_axi.r_valid) begin
                    burst_buf_nxt = {burst_buf[`DBG_DATA_BITS-1:0], i_axi.r_data};
                    if (burst_cnt == burst_len) begin
                        o_resp_valid = 1'b1;
                        o_resp_rdata = select_rdata(offs, burst_buf_nxt);
                        state_nxt    = s_idle;
                    end else begin
                        burst_cnt_nxt = burst_cnt + 8'd1;
                    end
                end
            end
            s_write_data: begin
                o_axi.w_valid = 1'b1;
                if (i_axi.w_ready) begin
                    state_nxt = s_write_resp;
                end
            end
            s_write_resp: begin
                if (i_axi.b_valid) begin
                    o_resp_valid = 1'b1;
                    state_nxt    = s_idle;
                end
            end
            default: state_nxt = s_idle;
        endcase

        // Address handshakes, whether from idle or from a waiting state.
        if (o_axi.ar_valid && i_axi.ar_ready) begin
            o_req_ready   = 1'b1;
            offs_nxt      = i_req.addr[2:1];
            burst_len_nxt = rd_ax.len;
            burst_cnt_nxt = '0;
            state_nxt     = s_read_data;
        end
        if (o_axi.aw_valid && i_axi.aw_ready) begin
            o_req_ready = 1'b1;
            w_data_nxt  = i_req.wdata;
            w_strb_nxt  = i_req.wstrb;
            state_nxt   = s_write_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state     <= s_idle;
            burst_cnt <= '0;
            burst_len <= '0;
        end else begin
            state     <= state_nxt;
            burst_cnt <= burst_cnt_nxt;
            burst_len <= burst_len_nxt;
        end
    end

    // Data path registers.
    always_ff @(posedge clk) begin
        offs      <= offs_nxt;
        burst_buf <= burst_buf_nxt;
        w_data    <= w_data_nxt;
        w_strb    <= w_strb_nxt;
    end

endmodule

`default_nettype wire

// File: hw/dbg_bridge_consts.svh
`ifndef DBG_BRIDGE_CONSTS_SVH
`define DBG_BRIDGE_CONSTS_SVH

// Width of a byte address on the bridge bus.
`define DBG_ADDR_BITS 16

// Width of one AXI data beat.
`define DBG_DATA_BITS 64

// Depth of the SRAM behind the slave, in 64-bit words.
`define SRAM_WORDS 1024

// AXI4 burst type codes.
`define AXI_BURST_FIXED 2'b00
`define AXI_BURST_INCR  2'b01

// AXI4 size code for an 8-byte beat.
`define AXI_SIZE_8B 3'd3

`endif

// File: hw/dbg_bridge_pkg.sv
`default_nettype none

`include "dbg_bridge_consts.svh"

package dbg_bridge_pkg;

    // Byte address as seen by the host and the AXI address channels.
    typedef logic [`DBG_ADDR_BITS-1:0] dbg_addr_t;

    // One data word, the width of a single AXI beat.
    typedef logic [`DBG_DATA_BITS-1:0] dbg_data_t;

    // Byte enables, one bit per byte of a data word.
    typedef logic [`DBG_DATA_BITS/8-1:0] dbg_strb_t;

    // Number of beats in a burst, minus one.
    typedef logic [7:0] axi_len_t;

    // A single request from the host side.
    typedef struct packed {
        logic      wr;    // High for a write, low for a read.
        dbg_addr_t addr;
        dbg_data_t wdata;
        dbg_strb_t wstrb;
    } dbg_req_t;

    // Address channel payload, shared by AW and AR.
    typedef struct packed {
        dbg_addr_t addr;
        axi_len_t  len;
        logic [2:0] size;
        logic [1:0] burst;
    } axi_ax_t;

    // Everything the master drives towards the slave.
    typedef struct packed {
        logic      aw_valid;
        axi_ax_t   aw;
        logic      w_valid;
        dbg_data_t w_data;
        dbg_strb_t w_strb;
        logic      w_last;
        logic      ar_valid;
        axi_ax_t   ar;
    } axi_m2s_t;

    // Everything the slave drives back to the master.
    // There are no b_ready or r_ready lines, since the master always accepts.
    typedef struct packed {
        logic      aw_ready;
        logic      w_ready;
        logic      b_valid;
        logic      ar_ready;
        logic      r_valid;
        dbg_data_t r_data;
        logic      r_last;
    } axi_s2m_t;

endpackage

`default_nettype wire

// File: hw/dbg_bridge_top.sv
`default_nettype none

module dbg_bridge_top import dbg_bridge_pkg::*; (
    input  wire logic     clk,
    input  wire logic     nrst,
    input  wire logic     i_req_valid,
    input  wire dbg_req_t i_req,
    output logic          o_req_ready,
    output logic          o_resp_valid,
    output dbg_data_t     o_resp_rdata
);

    wire axi_m2s_t axi_m2s;  // Master to slave channels.
    wire axi_s2m_t axi_s2m;  // Slave to master channels.

    // Turns host requests into AXI4 transactions.
    dbg_axi_master master_i (
        .clk          (clk),
        .nrst         (nrst),
        .i_req_valid  (i_req_valid),
        .i_req        (i_req),
        .o_req_ready  (o_req_ready),
        .o_resp_valid (o_resp_valid),
        .o_resp_rdata (o_resp_rdata),
        .o_axi        (axi_m2s),
        .i_axi        (axi_s2m)
    );

    // Memory at the far end of the bus.
    axi_sram_slave sram_i (
        .clk   (clk),
        .nrst  (nrst),
        .i_axi (axi_m2s),
        .o_axi (axi_s2m)
    );

endmodule

`default_nettype wire

// File: verif/dbg_bridge_tests.txt
# Columns: name, W or R, hex byte address, hex write data, hex strobes, hex expected read data.
# Write lines carry zero as expected data; it is not checked.
wr_full_a   W 0100 0123456789abcdef ff 0000000000000000
rd_full_a   R 0100 0000000000000000 00 0123456789abcdef
wr_low_a    W 0100 1111111122222222 0f 0000000000000000
rd_low_a    R 0100 0000000000000000 00 0123456722222222
wr_full_b   W 0108 aabbccddeeff0011 ff 0000000000000000
wr_high_b   W 0108 5566778899aabbcc f0 0000000000000000
rd_high_b   R 0108 0000000000000000 00 55667788eeff0011
rd_off1_a   R 0102 0000000000000000 00 0000012345672222
rd_off2_a   R 0104 0000000000000000 00 0000000001234567
rd_off3_a   R 0106 0000000000000000 00 7788eeff00110123
rd_off1_b   R 010a 0000000000000000 00 000055667788eeff
wr_full_c   W 0200 8899aabbccddeeff ff 0000000000000000
wr_full_d   W 0208 0011223344556677 ff 0000000000000000
rd_off3_c   R 0206 0000000000000000 00 2233445566778899
rd_off1_c   R 0202 0000000000000000 00 00008899aabbccdd
rd_off2_d   R 020c 0000000000000000 00 0000000000112233
wr_mix_d    W 0208 ffffffffffffffff 5a 0000000000000000
rd_mix_d    R 0208 0000000000000000 00 00ff22ffff55ff77
wr_full_e   W 0210 cafef00ddeadbeef ff 0000000000000000
rd_off3_d   R 020e 0000000000000000 00 f00ddeadbeef00ff
wr_none_e   W 0210 1234567812345678 00 0000000000000000
rd_none_e   R 0210 0000000000000000 00 cafef00ddeadbeef
wr_sub_e    W 0216 0102030405060708 03 0000000000000000
rd_sub_e    R 0210 0000000000000000 00 cafef00ddead0708
rd_again_a  R 0100 0000000000000000 00 0123456722222222

// File: verif/tb_dbg_bridge.sv
`default_nettype none

module tb_dbg_bridge import dbg_bridge_pkg::*; ();

    localparam int    CLK_PERIOD = 4;
    localparam int    WAIT_LIMIT = 16;  // Cycles allowed for one handshake.
    localparam string TEST_FILE  = "verif/dbg_bridge_tests.txt";

    logic      clk = 1'b0;
    logic      nrst;
    logic      req_valid;
    dbg_req_t  req;
    logic      req_ready;
    logic      resp_valid;
    dbg_data_t resp_rdata;

    // Test vectors as read from the file, one entry per line.
    string     names[$];
    dbg_req_t  reqs[$];
    dbg_data_t exp_rdata[$];

    int   n_tests = 0;
    int   pass_count = 0;
    int   fail_count = 0;
    int   load_errors = 0;
    int   mon_errors = 0;          // Counted by the monitor only.
    int   resp_count = 0;          // Counted by the monitor only.
    logic resp_expected = 1'b0;    // High while a request waits for its response.
    logic tests_loaded = 1'b0;

    dbg_bridge_top dut_i (
        .clk          (clk),
        .nrst         (nrst),
        .i_req_valid  (req_valid),
        .i_req        (req),
        .o_req_ready  (req_ready),
        .o_resp_valid (resp_valid),
        .o_resp_rdata (resp_rdata)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Outputs are sampled on the falling edge, half a cycle away from any input change.
    always @(negedge clk) begin
        if (resp_valid) begin
            resp_count++;
            if (!resp_expected) begin
                $display("Stray o_resp_valid at time %0t with no request waiting.", $time);
                mon_errors++;
            end
        end
        if (req_ready && !req_valid) begin
            $display("o_req_ready pulsed at time %0t with no request present.", $time);
            mon_errors++;
        end
    end

    task automatic load_tests();
        int          fd;
        int          n_fields;
        string       line;
        string       name;
        string       op;
        dbg_addr_t   addr;
        dbg_data_t   wdata;
        dbg_strb_t   wstrb;
        dbg_data_t   expd;
        dbg_req_t    r;

        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the test file %s.", TEST_FILE);
            load_errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line[0] != "#") begin  // Skip blanks and comments.
                    n_fields = $sscanf(line, "%s %s %h %h %h %h",
                                       name, op, addr, wdata, wstrb, expd);
                    if (n_fields != 6 || (op != "W" && op != "R")) begin
                        $display("Malformed test line: %s", line);
                        load_errors++;
                    end else begin
                        r.wr    = (op == "W");
                        r.addr  = addr;
                        r.wdata = wdata;
                        r.wstrb = wstrb;
                        names.push_back(name);
                        reqs.push_back(r);
                        exp_rdata.push_back(expd);
                    end
                end
            end
            $fclose(fd);
        end
        n_tests = names.size();
        if (n_tests == 0) begin
            $display("No tests were loaded.");
            load_errors++;
        end
    endtask

    // Sends one request, then waits for its single response.
    task automatic run_test(input int idx);
        int   wait_cnt;
        logic ok;

        ok = 1'b1;
        @(posedge clk);
        resp_expected = 1'b0;
        req_valid <= 1'b1;
        req       <= reqs[idx];

        wait_cnt = 0;
        @(negedge clk);
        while (!req_ready && wait_cnt < WAIT_LIMIT) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (!req_ready) begin
            $display("%s: the bridge never took the request.", names[idx]);
            ok = 1'b0;
        end
        @(posedge clk);
        req_valid <= 1'b0;

        if (ok) begin
            resp_expected = 1'b1;
            wait_cnt = 0;
            @(negedge clk);
            while (!resp_valid && wait_cnt < WAIT_LIMIT) begin
                @(negedge clk);
                wait_cnt++;
            end
            if (!resp_valid) begin
                $display("%s: no response arrived.", names[idx]);
                ok = 1'b0;
            end else if (!reqs[idx].wr && resp_rdata !== exp_rdata[idx]) begin
                $display("** Error at time %0t: %s read 0x%04h returned %016h, expected %016h",
                         $time, names[idx], reqs[idx].addr, resp_rdata, exp_rdata[idx]);
                ok = 1'b0;
            end
        end

        if (ok) begin
            pass_count++;
            $display("ok      %s", names[idx]);
        end else begin
            fail_count++;
            $display("failed  %s", names[idx]);
        end
    endtask

    initial begin
        logic reset_ok;
        int   other_errors;

        nrst      <= 1'b0;
        req_valid <= 1'b0;
        req       <= '0;
        load_tests();
        tests_loaded = 1'b1;

        // Reset covers three rising edges, then two quiet cycles follow.
        reset_ok = 1'b1;
        for (int i = 0; i < 5; i++) begin
            @(posedge clk);
            if (i == 2) begin
                nrst <= 1'b1;
            end
            @(negedge clk);
            if (req_ready || resp_valid) begin
                reset_ok = 1'b0;
            end
        end
        if (reset_ok) begin
            pass_count++;
            $display("ok      reset");
        end else begin
            fail_count++;
            $display("failed  reset: ready or response strobe seen around reset");
        end

        for (int idx = 0; idx < n_tests; idx++) begin
            run_test(idx);
        end
        @(posedge clk);
        resp_expected = 1'b0;
        repeat (4) @(negedge clk);  // Room for a late or doubled response.

        other_errors = load_errors + mon_errors;
        if (resp_count != n_tests) begin
            $display("Saw %0d responses for %0d requests.", resp_count, n_tests);
            other_errors++;
        end
        $display("Tests: %0d passed, %0d failed, %0d other errors",
                 pass_count, fail_count, other_errors);
        if (fail_count == 0 && other_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Ends a hung run; the limit scales with the number of tests.
    initial begin
        longint limit;

        wait (tests_loaded);
        limit = longint'(n_tests + 2) * 20 * CLK_PERIOD;
        #(limit);
        $display("Timeout: the run was still going after %0d time units.", limit);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire
